/* rtl/ddr3_params.svh */
`ifndef DDR3_PARAMS_SVH
`define DDR3_PARAMS_SVH

// Geometry of one DDR3 device
`define DDR_BANKS      8
`define DDR_BANK_BITS  3
`define DDR_ROW_BITS   13
`define DDR_COL_BITS   10

// Request address is {bank, row, col}
`define DDR_ADDR_BITS  26

// DFI data path
`define DDR_DATA_BITS  32
`define DDR_MASK_BITS  4    // One bit per byte lane
`define DDR_TAG_BITS   4

// Latencies in controller clocks
`define DDR_CL         6
`define DDR_CWL        6

// Minimum command spacings in clocks
`define DDR_TRCD       3    // ACT to RD/WR
`define DDR_TRP        3    // PRE to ACT
`define DDR_TRAS       8    // ACT to PRE

// Command encodings as {ras_n, cas_n, we_n}
`define DDR_CMD_NOP    3'b111
`define DDR_CMD_ACT    3'b011
`define DDR_CMD_RD     3'b101
`define DDR_CMD_WR     3'b100
`define DDR_CMD_PRE    3'b010

`endif

/* rtl/ddr3_pkg.sv */
`default_nettype none
`include "ddr3_params.svh"

package ddr3_pkg;

  // One DFI address word. ACT reads it as a row, RD/WR as a column
  typedef union packed {
    logic [`DDR_ROW_BITS-1:0] row;
    struct packed {
      logic [1:0]               spare;
      logic                     ap;   // A10 auto-precharge
      logic [`DDR_COL_BITS-1:0] col;
    } col;
  } ddr3_dfi_addr_u;

endpackage

`default_nettype wire

/* rtl/ddr3_req_decode.sv */
`default_nettype none
`include "ddr3_params.svh"

module ddr3_req_decode (
  input  logic                      clock,
  input  logic                      rst_n_i,

  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  logic                      req_we_i,
  input  logic [`DDR_ADDR_BITS-1:0] req_addr_i,
  input  logic [`DDR_TAG_BITS-1:0]  req_tag_i,
  input  logic [`DDR_DATA_BITS-1:0] req_wdata_i,
  input  logic [`DDR_MASK_BITS-1:0] req_wmask_i,

  input  logic [`DDR_BANKS-1:0]     bank_busy_i,
  output logic [`DDR_BANKS-1:0]     bank_load_o,
  output logic                      bank_we_o,
  output logic [`DDR_ROW_BITS-1:0]  bank_row_o,
  output logic [`DDR_COL_BITS-1:0]  bank_col_o,
  output logic [`DDR_TAG_BITS-1:0]  bank_tag_o,
  output logic [`DDR_DATA_BITS-1:0] bank_wdata_o,
  output logic [`DDR_MASK_BITS-1:0] bank_wmask_o
);

  logic [`DDR_BANK_BITS-1:0] req_bank;

  // Address split, bank on top
  assign req_bank   = req_addr_i[`DDR_ADDR_BITS-1 -: `DDR_BANK_BITS];
  assign bank_row_o = req_addr_i[`DDR_COL_BITS +: `DDR_ROW_BITS];
  assign bank_col_o = req_addr_i[`DDR_COL_BITS-1:0];

  // Shared fields, only the loaded bank takes them
  assign bank_we_o    = req_we_i;
  assign bank_tag_o   = req_tag_i;
  assign bank_wdata_o = req_wdata_i;
  assign bank_wmask_o = req_wmask_i;

  // Stall only for a bank that still holds a request
  assign req_ready_o = ~bank_busy_i[req_bank];

  always_comb begin
    bank_load_o = '0;
    if (req_valid_i && req_ready_o) begin
      bank_load_o[req_bank] = 1'b1;
    end
  end

  // A bank machine never gets a second request on top of its first
  a_load_not_busy: assert property (
    @(posedge clock) disable iff (!rst_n_i)
    (bank_load_o & bank_busy_i) == '0
  );

endmodule

`default_nettype wire

/* rtl/ddr3_bank_fsm.sv */
`default_nettype none
`include "ddr3_params.svh"

module ddr3_bank_fsm
  import ddr3_pkg::*;
(
  input  logic                      clock,
  input  logic                      rst_n_i,

  input  logic                      load_i,
  input  logic                      we_i,
  input  logic [`DDR_ROW_BITS-1:0]  row_i,
  input  logic [`DDR_COL_BITS-1:0]  col_i,
  input  logic [`DDR_TAG_BITS-1:0]  tag_i,
  input  logic [`DDR_DATA_BITS-1:0] wdata_i,
  input  logic [`DDR_MASK_BITS-1:0] wmask_i,
  output logic                      busy_o,

  output logic                      cmd_req_o,
  input  logic                      grant_i,
  output logic [2:0]                cmd_code_o,
  output ddr3_dfi_addr_u            cmd_addr_o,
  output logic [`DDR_TAG_BITS-1:0]  cmd_tag_o,
  output logic [`DDR_DATA_BITS-1:0] cmd_wdata_o,
  output logic [`DDR_MASK_BITS-1:0] cmd_wmask_o
);

  localparam int CNT_BITS = 4;

  logic                     held_q;
  logic                     we_q;
  logic [`DDR_ROW_BITS-1:0] row_q;
  logic [`DDR_COL_BITS-1:0] col_q;
  logic                     row_open_q;
  logic [`DDR_ROW_BITS-1:0] open_row_q;
  logic [CNT_BITS-1:0]      wait_cnt_q;   // tRP / tRCD hold-off
  logic [CNT_BITS-1:0]      ras_cnt_q;    // tRAS before PRE
  logic                     row_hit;

  assign busy_o  = held_q;
  assign row_hit = row_open_q && (open_row_q == row_q);

  // Open-page choice of the next command
  always_comb begin
    cmd_addr_o = '0;
    if (row_hit) begin
      cmd_code_o         = we_q ? `DDR_CMD_WR : `DDR_CMD_RD;
      cmd_addr_o.col.col = col_q;
    end else if (row_open_q) begin
      cmd_code_o = `DDR_CMD_PRE;        // A10 low, this bank only
    end else begin
      cmd_code_o     = `DDR_CMD_ACT;
      cmd_addr_o.row = row_q;
    end
  end

  assign cmd_req_o = held_q && (wait_cnt_q == '0) &&
                     (row_hit || !row_open_q || (ras_cnt_q == '0));

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      held_q     <= 1'b0;
      row_open_q <= 1'b0;
      wait_cnt_q <= '0;
      ras_cnt_q  <= '0;
    end else begin
      if (wait_cnt_q != '0) wait_cnt_q <= wait_cnt_q - 1'b1;
      if (ras_cnt_q != '0) ras_cnt_q <= ras_cnt_q - 1'b1;
      if (load_i) held_q <= 1'b1;

      if (grant_i) begin
        case (cmd_code_o)
          `DDR_CMD_ACT: begin
            row_open_q <= 1'b1;
            wait_cnt_q <= CNT_BITS'(`DDR_TRCD - 1);
            ras_cnt_q  <= CNT_BITS'(`DDR_TRAS - 1);
          end
          `DDR_CMD_PRE: begin
            row_open_q <= 1'b0;
            wait_cnt_q <= CNT_BITS'(`DDR_TRP - 1);
          end
          default: held_q <= 1'b0;      // RD or WR retires the request
        endcase
      end
    end
  end

  // Request payload
  always_ff @(posedge clock) begin
    if (load_i) begin
      we_q        <= we_i;
      row_q       <= row_i;
      col_q       <= col_i;
      cmd_tag_o   <= tag_i;
      cmd_wdata_o <= wdata_i;
      cmd_wmask_o <= wmask_i;
    end
    if (grant_i && cmd_code_o == `DDR_CMD_ACT) open_row_q <= row_q;
  end

  a_rdwr_row_open: assert property (
    @(posedge clock) disable iff (!rst_n_i)
    cmd_req_o && (cmd_code_o == `DDR_CMD_RD || cmd_code_o == `DDR_CMD_WR)
      |-> row_open_q && (open_row_q == row_q)
  );

  // The arbiter must only grant a raised request
  a_grant_needs_req: assert property (
    @(posedge clock) disable iff (!rst_n_i)
    grant_i |-> cmd_req_o
  );

endmodule

`default_nettype wire

/* rtl/ddr3_cmd_arb.sv */
`default_nettype none
`include "ddr3_params.svh"

module ddr3_cmd_arb
  import ddr3_pkg::*;
(
  input  logic                      clock,
  input  logic                      rst_n_i,

  input  logic [`DDR_BANKS-1:0]     cmd_req_i,
  output logic [`DDR_BANKS-1:0]     cmd_grant_o,
  input  logic [2:0]                cmd_code_i  [`DDR_BANKS],
  input  ddr3_dfi_addr_u            cmd_addr_i  [`DDR_BANKS],
  input  logic [`DDR_TAG_BITS-1:0]  cmd_tag_i   [`DDR_BANKS],
  input  logic [`DDR_DATA_BITS-1:0] cmd_wdata_i [`DDR_BANKS],
  input  logic [`DDR_MASK_BITS-1:0] cmd_wmask_i [`DDR_BANKS],

  output logic                      dfi_rst_no,
  output logic                      dfi_cke_o,
  output logic                      dfi_cs_no,
  output logic                      dfi_ras_no,
  output logic                      dfi_cas_no,
  output logic                      dfi_we_no,
  output logic [`DDR_BANK_BITS-1:0] dfi_bank_o,
  output logic [`DDR_ROW_BITS-1:0]  dfi_addr_o,
  output logic                      dfi_wren_o,
  output logic [`DDR_MASK_BITS-1:0] dfi_mask_o,   // Set bit enables the byte
  output logic [`DDR_DATA_BITS-1:0] dfi_data_o,
  input  logic                      dfi_valid_i,
  input  logic [`DDR_DATA_BITS-1:0] dfi_data_i,

  output logic                      rsp_valid_o,
  output logic [`DDR_TAG_BITS-1:0]  rsp_tag_o,
  output logic [`DDR_DATA_BITS-1:0] rsp_rdata_o
);

  localparam int BB        = `DDR_BANK_BITS;
  localparam int TAG_DEPTH = 1 << $clog2(`DDR_CL + 2);  // Covers every RD in flight
  localparam int PTR_BITS  = $clog2(TAG_DEPTH);

  logic [BB-1:0]             last_q;
  logic [BB-1:0]             sel;
  logic                      any_grant;
  logic                      is_wr;
  logic                      is_rd;
  logic                      mem_up_q;
  logic [`DDR_CWL-1:0]       wr_en_q;
  logic [`DDR_DATA_BITS-1:0] wr_data_q [`DDR_CWL];
  logic [`DDR_MASK_BITS-1:0] wr_mask_q [`DDR_CWL];
  logic [`DDR_TAG_BITS-1:0]  tag_mem [TAG_DEPTH];
  logic [PTR_BITS-1:0]       tag_wr_q;
  logic [PTR_BITS-1:0]       tag_rd_q;
  logic [PTR_BITS:0]         tag_cnt_q;

  // Rotating priority starting just after the last winner
  always_comb begin
    logic [BB-1:0] idx;
    sel         = last_q;
    any_grant   = 1'b0;
    cmd_grant_o = '0;
    for (int i = 1; i <= `DDR_BANKS; i++) begin
      idx = last_q + BB'(i);
      if (!any_grant && cmd_req_i[idx]) begin
        any_grant = 1'b1;
        sel       = idx;
      end
    end
    if (any_grant) cmd_grant_o[sel] = 1'b1;
  end

  assign is_wr = any_grant && (cmd_code_i[sel] == `DDR_CMD_WR);
  assign is_rd = any_grant && (cmd_code_i[sel] == `DDR_CMD_RD);

  // No init sequence, memory is taken as ready
  assign dfi_rst_no = mem_up_q;
  assign dfi_cke_o  = mem_up_q;

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mem_up_q   <= 1'b0;
      last_q     <= '1;                 // Bank 0 wins first
      dfi_cs_no  <= 1'b1;
      {dfi_ras_no, dfi_cas_no, dfi_we_no} <= `DDR_CMD_NOP;
      wr_en_q    <= '0;
      dfi_wren_o <= 1'b0;
      tag_wr_q   <= '0;
      tag_rd_q   <= '0;
      tag_cnt_q  <= '0;
      rsp_valid_o <= 1'b0;
    end else begin
      mem_up_q  <= 1'b1;
      dfi_cs_no <= !any_grant;
      {dfi_ras_no, dfi_cas_no, dfi_we_no} <= any_grant ? cmd_code_i[sel] : `DDR_CMD_NOP;
      if (any_grant) last_q <= sel;

      wr_en_q    <= {wr_en_q[`DDR_CWL-2:0], is_wr};
      dfi_wren_o <= wr_en_q[`DDR_CWL-1];

      if (is_rd) tag_wr_q <= tag_wr_q + 1'b1;
      if (dfi_valid_i) tag_rd_q <= tag_rd_q + 1'b1;
      tag_cnt_q   <= tag_cnt_q + is_rd - dfi_valid_i;
      rsp_valid_o <= dfi_valid_i;
    end
  end

  always_ff @(posedge clock) begin
    dfi_bank_o   <= sel;
    dfi_addr_o   <= cmd_addr_i[sel];
    wr_data_q[0] <= cmd_wdata_i[sel];
    wr_mask_q[0] <= cmd_wmask_i[sel];
    for (int k = 1; k < `DDR_CWL; k++) begin
      wr_data_q[k] <= wr_data_q[k-1];
      wr_mask_q[k] <= wr_mask_q[k-1];
    end
    dfi_data_o <= wr_data_q[`DDR_CWL-1];  // Lands CWL after the WR cycle
    dfi_mask_o <= wr_mask_q[`DDR_CWL-1];
    if (is_rd) tag_mem[tag_wr_q] <= cmd_tag_i[sel];
    rsp_tag_o   <= tag_mem[tag_rd_q];
    rsp_rdata_o <= dfi_data_i;
  end

  a_grant_onehot: assert property (
    @(posedge clock) disable iff (!rst_n_i)
    $onehot0(cmd_grant_o)
  );

  // Read data without an outstanding RD means a lost or extra beat
  a_tag_no_underflow: assert property (
    @(posedge clock) disable iff (!rst_n_i)
    dfi_valid_i |-> tag_cnt_q != '0
  );

endmodule

`default_nettype wire

/* rtl/ddr3_ctrl_top.sv */
`default_nettype none
`include "ddr3_params.svh"

module ddr3_ctrl_top
  import ddr3_pkg::*;
(
  input  logic                      clock,
  input  logic                      rst_n_i,

  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  logic                      req_we_i,
  input  logic [`DDR_ADDR_BITS-1:0] req_addr_i,
  input  logic [`DDR_TAG_BITS-1:0]  req_tag_i,
  input  logic [`DDR_DATA_BITS-1:0] req_wdata_i,
  input  logic [`DDR_MASK_BITS-1:0] req_wmask_i,

  output logic                      rsp_valid_o,
  output logic [`DDR_TAG_BITS-1:0]  rsp_tag_o,
  output logic [`DDR_DATA_BITS-1:0] rsp_rdata_o,

  output logic                      dfi_rst_no,
  output logic                      dfi_cke_o,
  output logic                      dfi_cs_no,
  output logic                      dfi_ras_no,
  output logic                      dfi_cas_no,
  output logic                      dfi_we_no,
  output logic [`DDR_BANK_BITS-1:0] dfi_bank_o,
  output logic [`DDR_ROW_BITS-1:0]  dfi_addr_o,
  output logic                      dfi_wren_o,
  output logic [`DDR_MASK_BITS-1:0] dfi_mask_o,
  output logic [`DDR_DATA_BITS-1:0] dfi_data_o,
  input  logic                      dfi_valid_i,
  input  logic [`DDR_DATA_BITS-1:0] dfi_data_i
);

  // Decoder to bank machines
  logic [`DDR_BANKS-1:0]     bank_load;
  logic [`DDR_BANKS-1:0]     bank_busy;
  logic                      bank_we;
  logic [`DDR_ROW_BITS-1:0]  bank_row;
  logic [`DDR_COL_BITS-1:0]  bank_col;
  logic [`DDR_TAG_BITS-1:0]  bank_tag;
  logic [`DDR_DATA_BITS-1:0] bank_wdata;
  logic [`DDR_MASK_BITS-1:0] bank_wmask;

  // Bank machines to arbiter
  logic [`DDR_BANKS-1:0]     cmd_req;
  logic [`DDR_BANKS-1:0]     cmd_grant;
  logic [2:0]                cmd_code  [`DDR_BANKS];
  ddr3_dfi_addr_u            cmd_addr  [`DDR_BANKS];
  logic [`DDR_TAG_BITS-1:0]  cmd_tag   [`DDR_BANKS];
  logic [`DDR_DATA_BITS-1:0] cmd_wdata [`DDR_BANKS];
  logic [`DDR_MASK_BITS-1:0] cmd_wmask [`DDR_BANKS];

  ddr3_req_decode ddr3_req_decode_inst (
    .clock        (clock),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .req_we_i     (req_we_i),
    .req_addr_i   (req_addr_i),
    .req_tag_i    (req_tag_i),
    .req_wdata_i  (req_wdata_i),
    .req_wmask_i  (req_wmask_i),
    .bank_busy_i  (bank_busy),
    .bank_load_o  (bank_load),
    .bank_we_o    (bank_we),
    .bank_row_o   (bank_row),
    .bank_col_o   (bank_col),
    .bank_tag_o   (bank_tag),
    .bank_wdata_o (bank_wdata),
    .bank_wmask_o (bank_wmask)
  );

  // One open-page machine per bank
  for (genvar b = 0; b < `DDR_BANKS; b++) begin : g_bank
    ddr3_bank_fsm ddr3_bank_fsm_inst (
      .clock       (clock),
      .rst_n_i     (rst_n_i),
      .load_i      (bank_load[b]),
      .we_i        (bank_we),
      .row_i       (bank_row),
      .col_i       (bank_col),
      .tag_i       (bank_tag),
      .wdata_i     (bank_wdata),
      .wmask_i     (bank_wmask),
      .busy_o      (bank_busy[b]),
      .cmd_req_o   (cmd_req[b]),
      .grant_i     (cmd_grant[b]),
      .cmd_code_o  (cmd_code[b]),
      .cmd_addr_o  (cmd_addr[b]),
      .cmd_tag_o   (cmd_tag[b]),
      .cmd_wdata_o (cmd_wdata[b]),
      .cmd_wmask_o (cmd_wmask[b])
    );
  end

  ddr3_cmd_arb ddr3_cmd_arb_inst (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .cmd_req_i   (cmd_req),
    .cmd_grant_o (cmd_grant),
    .cmd_code_i  (cmd_code),
    .cmd_addr_i  (cmd_addr),
    .cmd_tag_i   (cmd_tag),
    .cmd_wdata_i (cmd_wdata),
    .cmd_wmask_i (cmd_wmask),
    .dfi_rst_no  (dfi_rst_no),
    .dfi_cke_o   (dfi_cke_o),
    .dfi_cs_no   (dfi_cs_no),
    .dfi_ras_no  (dfi_ras_no),
    .dfi_cas_no  (dfi_cas_no),
    .dfi_we_no   (dfi_we_no),
    .dfi_bank_o  (dfi_bank_o),
    .dfi_addr_o  (dfi_addr_o),
    .dfi_wren_o  (dfi_wren_o),
    .dfi_mask_o  (dfi_mask_o),
    .dfi_data_o  (dfi_data_o),
    .dfi_valid_i (dfi_valid_i),
    .dfi_data_i  (dfi_data_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_tag_o   (rsp_tag_o),
    .rsp_rdata_o (rsp_rdata_o)
  );

endmodule

`default_nettype wire

/* test/ddr3_dfi_model.sv */
`default_nettype none
`include "ddr3_params.svh"

module ddr3_dfi_model
  import ddr3_pkg::*;
(
  input  logic                      clock,
  input  logic                      dfi_rst_ni,
  input  logic                      dfi_cs_ni,
  input  logic                      dfi_ras_ni,
  input  logic                      dfi_cas_ni,
  input  logic                      dfi_we_ni,
  input  logic [`DDR_BANK_BITS-1:0] dfi_bank_i,
  input  ddr3_dfi_addr_u            dfi_addr_i,
  input  logic                      dfi_wren_i,
  input  logic [`DDR_MASK_BITS-1:0] dfi_mask_i,
  input  logic [`DDR_DATA_BITS-1:0] dfi_wdata_i,
  output logic                      dfi_valid_o,
  output logic [`DDR_DATA_BITS-1:0] dfi_rdata_o,
  output logic                      error_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ROW_LO   = 4;    // Low row bits kept in the array
  localparam int IDX_BITS = `DDR_BANK_BITS + ROW_LO + `DDR_COL_BITS;

  logic [`DDR_DATA_BITS-1:0] mem [1 << IDX_BITS];
  logic                      open_q [`DDR_BANKS];
  logic [`DDR_ROW_BITS-1:0]  row_q [`DDR_BANKS];
  longint                    act_cyc [`DDR_BANKS];
  longint                    pre_cyc [`DDR_BANKS];
  longint                    cyc;
  logic [IDX_BITS-1:0]       wr_idx_q [$];
  longint                    wr_due_q [$];
  logic [IDX_BITS-1:0]       rd_idx_q [$];
  longint                    rd_due_q [$];

  function automatic logic [`DDR_DATA_BITS-1:0] merge_bytes(
    input logic [`DDR_DATA_BITS-1:0] old_word,
    input logic [`DDR_DATA_BITS-1:0] new_word,
    input logic [`DDR_MASK_BITS-1:0] mask
  );
    logic [`DDR_DATA_BITS-1:0] r;
    r = old_word;
    for (int i = 0; i < `DDR_MASK_BITS; i++) begin
      if (mask[i]) r[8*i +: 8] = new_word[8*i +: 8];   // Set bit writes the byte
    end
    return r;
  endfunction

  task automatic protocol_error(input string what, input int bank);
    $display("DFI model error: %s (bank %0d, cycle %0d)", what, bank, cyc);
    error_o <= 1'b1;
  endtask

  initial begin
    for (int i = 0; i < (1 << IDX_BITS); i++) begin
      mem[i] = 32'h5a5a_5a5a ^ (i * 32'h0001_0003);   // Differs for every address
    end
    for (int b = 0; b < `DDR_BANKS; b++) begin
      open_q[b]  = 1'b0;
      act_cyc[b] = -100;
      pre_cyc[b] = -100;
    end
    cyc         = 0;
    dfi_valid_o = 1'b0;
    dfi_rdata_o = '0;
    error_o     = 1'b0;
  end

  always @(posedge clock) begin
    logic [2:0]                code;
    logic [`DDR_BANK_BITS-1:0] b;
    logic [IDX_BITS-1:0]       idx;
    cyc++;
    dfi_valid_o <= 1'b0;
    code = {dfi_ras_ni, dfi_cas_ni, dfi_we_ni};
    b    = dfi_bank_i;
    if (!dfi_rst_ni) begin
      wr_idx_q.delete();
      wr_due_q.delete();
      rd_idx_q.delete();
      rd_due_q.delete();
    end else begin
      // Write data lands before any read of the same cycle
      if (dfi_wren_i) begin
        if (wr_due_q.size() == 0) begin
          protocol_error("write data without a WR command", b);
        end else if (wr_due_q[0] != cyc) begin
          protocol_error("write data not CWL cycles after its WR", b);
        end else begin
          idx = wr_idx_q.pop_front();
          void'(wr_due_q.pop_front());
          mem[idx] = merge_bytes(mem[idx], dfi_wdata_i, dfi_mask_i);
        end
      end
      if (wr_due_q.size() != 0 && wr_due_q[0] < cyc) begin
        protocol_error("WR command never got its write data", b);
      end

      if (!dfi_cs_ni) begin
        case (code)
          `DDR_CMD_ACT: begin
            if (open_q[b]) protocol_error("ACT to a bank that already has an open row", b);
            else if (cyc - pre_cyc[b] < `DDR_TRP) protocol_error("ACT sooner than tRP", b);
            else begin
              open_q[b]  = 1'b1;
              row_q[b]   = dfi_addr_i.row;
              act_cyc[b] = cyc;
            end
          end
          `DDR_CMD_PRE: begin
            if (!open_q[b]) protocol_error("PRE to a bank with no open row", b);
            else if (cyc - act_cyc[b] < `DDR_TRAS) protocol_error("PRE sooner than tRAS", b);
            else begin
              open_q[b]  = 1'b0;
              pre_cyc[b] = cyc;
            end
          end
          `DDR_CMD_RD, `DDR_CMD_WR: begin
            if (!open_q[b]) protocol_error("RD or WR to a bank with no open row", b);
            else if (cyc - act_cyc[b] < `DDR_TRCD) protocol_error("RD or WR sooner than tRCD", b);
            else if (dfi_addr_i.col.ap) protocol_error("auto-precharge bit set", b);
            else begin
              idx = {b, row_q[b][ROW_LO-1:0], dfi_addr_i.col.col};
              if (code == `DDR_CMD_RD) begin
                rd_idx_q.push_back(idx);
                rd_due_q.push_back(cyc + `DDR_CL);
              end else begin
                wr_idx_q.push_back(idx);
                wr_due_q.push_back(cyc + `DDR_CWL);
              end
            end
          end
          default: protocol_error("chip select low with an unknown command", b);
        endcase
      end

      // Drive one cycle early so the DUT samples it CL after RD
      if (rd_due_q.size() != 0 && rd_due_q[0] == cyc + 1) begin
        dfi_valid_o <= 1'b1;
        dfi_rdata_o <= mem[rd_idx_q.pop_front()];
        void'(rd_due_q.pop_front());
      end
    end
  end

endmodule

`default_nettype wire

/* test/tb_ddr3_ctrl.sv */
`default_nettype none
`include "ddr3_params.svh"

module tb_ddr3_ctrl;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          CLK_PERIOD       = 100;
  localparam int          RESET_CYCLES     = 4;
  localparam int          CYCLES_PER_ENTRY = 40;
  localparam int          NUM_TAGS         = 1 << `DDR_TAG_BITS;
  localparam logic [15:0] LFSR_SEED        = 16'd26;
  localparam logic [15:0] LFSR_TAPS        = 16'hb400;
  localparam logic        WR               = 1'b1;
  localparam logic        RD               = 1'b0;

  logic                      clock;
  logic                      rst_n;
  logic                      req_valid;
  logic                      req_ready;
  logic                      req_we;
  logic [`DDR_ADDR_BITS-1:0] req_addr;
  logic [`DDR_TAG_BITS-1:0]  req_tag;
  logic [`DDR_DATA_BITS-1:0] req_wdata;
  logic [`DDR_MASK_BITS-1:0] req_wmask;
  logic                      rsp_valid;
  logic [`DDR_TAG_BITS-1:0]  rsp_tag;
  logic [`DDR_DATA_BITS-1:0] rsp_rdata;
  logic                      dfi_rst_n;
  logic                      dfi_cke;
  logic                      dfi_cs_n;
  logic                      dfi_ras_n;
  logic                      dfi_cas_n;
  logic                      dfi_we_n;
  logic [`DDR_BANK_BITS-1:0] dfi_bank;
  logic [`DDR_ROW_BITS-1:0]  dfi_addr;
  logic                      dfi_wren;
  logic [`DDR_MASK_BITS-1:0] dfi_mask;
  logic [`DDR_DATA_BITS-1:0] dfi_wdata;
  logic                      dfi_valid;
  logic [`DDR_DATA_BITS-1:0] dfi_rdata;
  logic                      model_error;

  // Stimulus table, one slot per entry
  logic                      tbl_we [$];
  logic [`DDR_ADDR_BITS-1:0] tbl_addr [$];
  logic [`DDR_TAG_BITS-1:0]  tbl_tag [$];
  logic [`DDR_DATA_BITS-1:0] tbl_wdata [$];
  logic [`DDR_MASK_BITS-1:0] tbl_mask [$];
  logic [`DDR_DATA_BITS-1:0] tbl_exp [$];

  logic [`DDR_DATA_BITS-1:0] exp_by_tag [NUM_TAGS];
  logic                      pend [NUM_TAGS];
  int                        pend_cnt;
  int                        rd_order [$];   // Open read tags, oldest first
  logic                      ooo_seen;
  logic [15:0]               lfsr_state;

  ddr3_ctrl_top ddr3_ctrl_top_inst (
    .clock       (clock),
    .rst_n_i     (rst_n),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .req_we_i    (req_we),
    .req_addr_i  (req_addr),
    .req_tag_i   (req_tag),
    .req_wdata_i (req_wdata),
    .req_wmask_i (req_wmask),
    .rsp_valid_o (rsp_valid),
    .rsp_tag_o   (rsp_tag),
    .rsp_rdata_o (rsp_rdata),
    .dfi_rst_no  (dfi_rst_n),
    .dfi_cke_o   (dfi_cke),
    .dfi_cs_no   (dfi_cs_n),
    .dfi_ras_no  (dfi_ras_n),
    .dfi_cas_no  (dfi_cas_n),
    .dfi_we_no   (dfi_we_n),
    .dfi_bank_o  (dfi_bank),
    .dfi_addr_o  (dfi_addr),
    .dfi_wren_o  (dfi_wren),
    .dfi_mask_o  (dfi_mask),
    .dfi_data_o  (dfi_wdata),
    .dfi_valid_i (dfi_valid),
    .dfi_data_i  (dfi_rdata)
  );

  ddr3_dfi_model ddr3_dfi_model_inst (
    .clock       (clock),
    .dfi_rst_ni  (dfi_rst_n),
    .dfi_cs_ni   (dfi_cs_n),
    .dfi_ras_ni  (dfi_ras_n),
    .dfi_cas_ni  (dfi_cas_n),
    .dfi_we_ni   (dfi_we_n),
    .dfi_bank_i  (dfi_bank),
    .dfi_addr_i  (dfi_addr),
    .dfi_wren_i  (dfi_wren),
    .dfi_mask_i  (dfi_mask),
    .dfi_wdata_i (dfi_wdata),
    .dfi_valid_o (dfi_valid),
    .dfi_rdata_o (dfi_rdata),
    .error_o     (model_error)
  );

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // One LFSR step per bit
  function automatic int take_random_bits(input int n);
    int v;
    v = 0;
    for (int k = 0; k < n; k++) begin
      v          = (v << 1) | lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  function automatic logic [`DDR_ADDR_BITS-1:0] make_addr(input int bank, input int row,
                                                          input int col);
    return {bank[`DDR_BANK_BITS-1:0], row[`DDR_ROW_BITS-1:0], col[`DDR_COL_BITS-1:0]};
  endfunction

  task automatic add_entry(input logic we, input int bank, input int row, input int col,
                           input int tag, input logic [31:0] wdata, input logic [3:0] mask,
                           input logic [31:0] exp);
    tbl_we.push_back(we);
    tbl_addr.push_back(make_addr(bank, row, col));
    tbl_tag.push_back(tag[`DDR_TAG_BITS-1:0]);
    tbl_wdata.push_back(wdata);
    tbl_mask.push_back(mask);
    tbl_exp.push_back(exp);
  endtask

  task automatic build_table();
    // kind, bank, row, col, tag, write data, mask, expected read data
    add_entry(WR, 0, 1, 'h005, 0, 32'h1122_3344, 4'hf, 32'h0);
    add_entry(RD, 0, 1, 'h005, 1, 32'h0, 4'h0, 32'h1122_3344);
    add_entry(WR, 1, 2, 'h009, 2, 32'ha0b0_c0d0, 4'hf, 32'h0);
    add_entry(WR, 1, 2, 'h009, 3, 32'h5566_7788, 4'b0101, 32'h0);   // Bytes 0 and 2
    add_entry(RD, 1, 2, 'h009, 4, 32'h0, 4'h0, 32'ha066_c088);
    add_entry(WR, 2, 3, 'h010, 5, 32'h0bad_f00d, 4'hf, 32'h0);
    add_entry(WR, 2, 7, 'h010, 6, 32'hcafe_babe, 4'hf, 32'h0);      // Row miss
    add_entry(RD, 2, 3, 'h010, 7, 32'h0, 4'h0, 32'h0bad_f00d);
    add_entry(RD, 2, 7, 'h010, 8, 32'h0, 4'h0, 32'hcafe_babe);
    add_entry(WR, 3, 4, 'h001, 9, 32'h1357_9bdf, 4'hf, 32'h0);
    add_entry(WR, 4, 4, 'h002, 10, 32'h2468_ace0, 4'hf, 32'h0);
    add_entry(WR, 5, 6, 'h003, 11, 32'hdead_beef, 4'hf, 32'h0);
    add_entry(WR, 6, 9, 'h007, 12, 32'h0f1e_2d3c, 4'hf, 32'h0);
    add_entry(WR, 6, 2, 'h008, 13, 32'h89ab_cdef, 4'hf, 32'h0);
    add_entry(RD, 6, 9, 'h007, 14, 32'h0, 4'h0, 32'h0f1e_2d3c);     // Slow miss
    add_entry(RD, 3, 4, 'h001, 15, 32'h0, 4'h0, 32'h1357_9bdf);     // Fast hit overtakes
    add_entry(RD, 4, 4, 'h002, 0, 32'h0, 4'h0, 32'h2468_ace0);
    add_entry(RD, 5, 6, 'h003, 1, 32'h0, 4'h0, 32'hdead_beef);
    add_entry(RD, 6, 2, 'h008, 3, 32'h0, 4'h0, 32'h89ab_cdef);
  endtask

  // Starts and ends on a falling edge
  task automatic send_request(input int i);
    logic ready;
    int   t;
    t = tbl_tag[i];
    if (!tbl_we[i]) begin
      if (pend[t]) begin
        stop_with_failure($sformatf("Entry %0d reuses tag %0d while its read is open", i, t));
      end
      pend[t]       = 1'b1;
      exp_by_tag[t] = tbl_exp[i];
      pend_cnt++;
      rd_order.push_back(t);
    end
    req_valid = 1'b1;
    req_we    = tbl_we[i];
    req_addr  = tbl_addr[i];
    req_tag   = tbl_tag[i];
    req_wdata = tbl_wdata[i];
    req_wmask = tbl_mask[i];
    #1;                                 // Ready follows the new address
    ready = req_ready;
    while (!ready) begin
      @(negedge clock);
      #1;
      ready = req_ready;
    end
    @(negedge clock);
    req_valid = 1'b0;
  endtask

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  // Response check by tag
  always @(negedge clock) begin
    int t;
    int pos;
    if (rst_n && rsp_valid) begin
      t = rsp_tag;
      if (!pend[t]) begin
        stop_with_failure($sformatf("Response with tag %0d but no read with that tag is open", t));
      end
      check_value($sformatf("rsp_rdata_o (tag %0d)", t), rsp_rdata, exp_by_tag[t]);
      if (rd_order[0] != t) ooo_seen = 1'b1;
      pos = 0;
      for (int k = 0; k < rd_order.size(); k++) begin
        if (rd_order[k] == t) pos = k;
      end
      rd_order.delete(pos);
      pend[t] = 1'b0;
      pend_cnt--;
    end
  end

  always @(posedge model_error) begin
    stop_with_failure("The DFI model saw a protocol violation");
  end

  initial begin
    @(posedge rst_n);
    repeat (tbl_we.size() * CYCLES_PER_ENTRY) @(posedge clock);
    stop_with_failure("Timeout: the requests did not all complete in time");
  end

  initial begin
    int gap;
    rst_n      = 1'b0;
    req_valid  = 1'b0;
    req_we     = 1'b0;
    req_addr   = '0;
    req_tag    = '0;
    req_wdata  = '0;
    req_wmask  = '0;
    lfsr_state = LFSR_SEED;
    pend_cnt   = 0;
    ooo_seen   = 1'b0;
    for (int k = 0; k < NUM_TAGS; k++) begin
      pend[k] = 1'b0;
    end
    build_table();

    repeat (RESET_CYCLES) @(negedge clock);
    check_value("dfi_rst_no in reset", dfi_rst_n, 0);
    check_value("dfi_cs_no in reset", dfi_cs_n, 1);
    rst_n = 1'b1;
    @(negedge clock);
    // Memory comes up one cycle after release, bus still idle
    check_value("dfi_rst_no", dfi_rst_n, 1);
    check_value("dfi_cke_o", dfi_cke, 1);
    check_value("dfi_cs_no", dfi_cs_n, 1);
    check_value("dfi ras/cas/we", {dfi_ras_n, dfi_cas_n, dfi_we_n}, `DDR_CMD_NOP);
    check_value("dfi_wren_o", dfi_wren, 0);
    check_value("rsp_valid_o", rsp_valid, 0);

    for (int i = 0; i < tbl_we.size(); i++) begin
      send_request(i);
      gap = take_random_bits(2);
      repeat (gap) @(negedge clock);
    end
    wait (pend_cnt == 0);
    @(negedge clock);
    check_value("out-of-order response seen", ooo_seen, 1);
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+rtl
rtl/ddr3_pkg.sv
rtl/ddr3_req_decode.sv
rtl/ddr3_bank_fsm.sv
rtl/ddr3_cmd_arb.sv
rtl/ddr3_ctrl_top.sv
test/ddr3_dfi_model.sv
test/tb_ddr3_ctrl.sv

/* Bender.yml */
package:
  name: ddr3_ctrl

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ddr3_pkg.sv
      - rtl/ddr3_req_decode.sv
      - rtl/ddr3_bank_fsm.sv
      - rtl/ddr3_cmd_arb.sv
      - rtl/ddr3_ctrl_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/ddr3_dfi_model.sv
      - test/tb_ddr3_ctrl.sv
